// ==== tb.f ====
common/bus_pkg.sv
common/gpio_pkg.sv
common/periph_if.sv
rtl/bus_port.sv
gpio/gpio_regs.sv
rtl/gray_coder.sv
rtl/pin_router.sv
rtl/periph_top.sv
verif/tb_periph_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the periph_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f tb.f --top-module tb_periph_top -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

// ==== verif/tb_periph_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_periph_top;

    localparam logic [1:0] ACC_WORD = 2'b10;  // Any code other than ACC_NONE

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_ui_in;
    logic [10:0] i_addr;
    logic [31:0] i_data;
    logic [1:0]  i_data_write_n;
    logic [1:0]  i_data_read_n;
    logic        i_data_read_complete;
    logic [31:0] o_data;
    logic        o_data_ready;
    logic [7:0]  o_uo_out;

    // Model of the register state
    logic [7:0]  m_out;
    logic [4:0]  m_sel [8];
    logic [7:0]  m_gray;

    periph_top u_periph_top (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [10:0] user_addr(input logic [3:0] slot, input logic [5:0] ofs);
        bus_pkg::periph_addr_t a;
        a = '0;
        a.user.slot   = slot;
        a.user.offset = ofs;
        return a;
    endfunction

    function automatic logic [10:0] byte_addr(input logic [3:0] slot, input logic [3:0] ofs);
        bus_pkg::periph_addr_t a;
        a = '0;
        a.simple.region = 1'b1;
        a.simple.slot   = slot;
        a.simple.offset = ofs;
        return a;
    endfunction

    function automatic logic [10:0] func_addr(input int pin);
        return user_addr(bus_pkg::GPIO_SLOT, gpio_pkg::OFS_FUNC_BASE + 6'(pin * 4));
    endfunction

    // Bit i of Gray code is v[i] xor v[i+1]
    function automatic logic [7:0] gray_of(input logic [7:0] v);
        logic [7:0] g;
        g[7] = v[7];
        for (int i = 0; i < 7; i++) g[i] = v[i] ^ v[i+1];
        return g;
    endfunction

    function automatic logic [7:0] gray_decode(input logic [7:0] v);
        logic [7:0] d;
        for (int i = 0; i < 8; i++) d[i] = ^(v >> i);  // Parity of bits i and above
        return d;
    endfunction

    function automatic logic [31:0] ref_read(input logic [10:0] addr, input logic [7:0] ui);
        bus_pkg::periph_addr_t a;
        logic [5:0]            ofs;
        logic [31:0]           r;
        a   = addr;
        ofs = a.user.offset;
        r   = '0;
        if (!a.user.region) begin
            if (a.user.slot == bus_pkg::GPIO_SLOT) begin
                if (ofs == gpio_pkg::OFS_OUT) r = {24'h0, m_out};
                else if (ofs == gpio_pkg::OFS_IN) r = {24'h0, ui};
                else if (ofs >= gpio_pkg::OFS_FUNC_BASE && ofs[1:0] == 2'b00)
                    r = {27'h0, m_sel[ofs[4:2]]};
            end
        end else if (a.simple.slot == bus_pkg::GRAY_SLOT) begin
            case (a.simple.offset)
                4'd0:    r = {24'h0, m_gray};
                4'd1:    r = {24'h0, gray_of(m_gray)};
                4'd2:    r = {24'h0, gray_decode(m_gray)};
                default: r = '0;
            endcase
        end
        return r;
    endfunction

    function automatic logic [7:0] ref_pins();
        logic [7:0] g;
        logic [7:0] p;
        g = gray_of(m_gray);
        for (int i = 0; i < 8; i++) begin
            if (m_sel[i] == gpio_pkg::FUNC_GPIO) p[i] = m_out[i];
            else if (m_sel[i] == gpio_pkg::FUNC_GRAY) p[i] = g[i];
            else p[i] = 1'b0;
        end
        return p;
    endfunction

    task automatic model_write(input logic [10:0] addr, input logic [31:0] data);
        bus_pkg::periph_addr_t a;
        a = addr;
        if (!a.user.region && a.user.slot == bus_pkg::GPIO_SLOT) begin
            if (a.user.offset == gpio_pkg::OFS_OUT) m_out = data[7:0];
            if (a.user.offset >= gpio_pkg::OFS_FUNC_BASE && a.user.offset[1:0] == 2'b00)
                m_sel[a.user.offset[4:2]] = data[4:0];
        end else if (a.simple.region && a.simple.slot == bus_pkg::GRAY_SLOT) begin
            if (a.simple.offset == 4'd0) m_gray = data[7:0];
        end
    endtask

    task automatic set_pins(input logic [7:0] val);
        @(posedge clk);
        #2;
        i_ui_in = val;
    endtask

    task automatic bus_write(input logic [10:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        i_addr         = addr;
        i_data         = data;
        i_data_write_n = ACC_WORD;
        #10;
        check("o_data_ready", 32'(o_data_ready), 32'h1);  // Same cycle as the write
        @(posedge clk);
        #2;
        i_data_write_n = bus_pkg::ACC_NONE;
        model_write(addr, data);
        #10;
    endtask

    task automatic start_read(input logic [10:0] addr);
        @(posedge clk);
        #2;
        i_addr        = addr;
        i_data_read_n = ACC_WORD;
        #10;
        check("o_data_ready", 32'(o_data_ready), 32'h0);  // Request cycle
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (o_data_ready !== 1'b1) begin
            if (cycles == 20) begin
                $display("Read was not answered within 20 cycles");
                stop_run();
            end else begin
                @(posedge clk);
                #12;
                cycles++;
            end
        end
    endtask

    task automatic finish_read();
        @(posedge clk);
        #2;
        i_data_read_n        = bus_pkg::ACC_NONE;
        i_data_read_complete = 1'b1;
        @(posedge clk);
        #2;
        i_data_read_complete = 1'b0;
        #10;
    endtask

    task automatic bus_read(input logic [10:0] addr, output logic [31:0] data);
        start_read(addr);
        wait_ready();
        data = o_data;
        finish_read();
    endtask

    task automatic read_check(input logic [10:0] addr);
        logic [31:0] d;
        bus_read(addr, d);
        check("o_data", d, ref_read(addr, i_ui_in));
    endtask

    initial begin
        logic [31:0] held;
        logic [7:0]  mask;
        logic [2:0]  p;
        void'($urandom(11187));
        rst_n                = 1'b0;
        i_ui_in              = '0;
        i_addr               = '0;
        i_data               = '0;
        i_data_write_n       = bus_pkg::ACC_NONE;
        i_data_read_n        = bus_pkg::ACC_NONE;
        i_data_read_complete = 1'b0;
        m_out                = '0;
        m_gray               = '0;
        for (int i = 0; i < 8; i++) m_sel[i] = gpio_pkg::FUNC_GPIO;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        #10;

        // Reset state
        check("o_uo_out", 32'(o_uo_out), 32'h0);
        read_check(user_addr(bus_pkg::GPIO_SLOT, gpio_pkg::OFS_OUT));
        for (int i = 0; i < 8; i++) read_check(func_addr(i));

        // GPIO output and input readback
        repeat (8) begin
            set_pins(8'($urandom()));
            bus_write(user_addr(bus_pkg::GPIO_SLOT, gpio_pkg::OFS_OUT), $urandom());
            check("o_uo_out", 32'(o_uo_out), 32'(ref_pins()));
            read_check(user_addr(bus_pkg::GPIO_SLOT, gpio_pkg::OFS_OUT));
            read_check(user_addr(bus_pkg::GPIO_SLOT, gpio_pkg::OFS_IN));
        end

        // Gray coder, offset 3 is unused
        repeat (8) begin
            bus_write(byte_addr(bus_pkg::GRAY_SLOT, 4'd0), $urandom());
            for (int o = 0; o < 4; o++) read_check(byte_addr(bus_pkg::GRAY_SLOT, 4'(o)));
        end

        // Pin routing with one pin on an empty user slot
        p    = 3'($urandom());
        mask = 8'($urandom());
        mask[p] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) bus_write(func_addr(i), 32'(gpio_pkg::FUNC_GRAY));
        end
        bus_write(func_addr(int'(p)), 32'h0000_0005);
        check("o_uo_out", 32'(o_uo_out), 32'(ref_pins()));
        for (int i = 0; i < 8; i++) read_check(func_addr(i));
        repeat (4) begin
            bus_write(byte_addr(bus_pkg::GRAY_SLOT, 4'd0), $urandom());
            check("o_uo_out", 32'(o_uo_out), 32'(ref_pins()));
            bus_write(user_addr(bus_pkg::GPIO_SLOT, gpio_pkg::OFS_OUT), $urandom());
            check("o_uo_out", 32'(o_uo_out), 32'(ref_pins()));
        end
        for (int i = 0; i < 8; i++) bus_write(func_addr(i), 32'(gpio_pkg::FUNC_GPIO));
        check("o_uo_out", 32'(o_uo_out), 32'(ref_pins()));

        // Hold o_data while the address moves to a register with a different value
        bus_write(byte_addr(bus_pkg::GRAY_SLOT, 4'd0), {24'h0, ~m_out});
        start_read(user_addr(bus_pkg::GPIO_SLOT, gpio_pkg::OFS_OUT));
        @(posedge clk);
        #12;
        check("o_data_ready", 32'(o_data_ready), 32'h1);  // One cycle after the request
        held = o_data;
        check("o_data", held, ref_read(user_addr(bus_pkg::GPIO_SLOT, gpio_pkg::OFS_OUT), i_ui_in));
        @(posedge clk);
        #2;
        i_addr = byte_addr(bus_pkg::GRAY_SLOT, 4'd0);
        @(posedge clk);
        #12;
        check("o_data", o_data, held);
        check("o_data_ready", 32'(o_data_ready), 32'h1);
        finish_read();

        read_check(byte_addr(4'd7, 4'd0));  // Empty byte slot

        // Empty user slot never answers
        start_read(user_addr(4'd5, 6'd0));
        repeat (5) begin
            @(posedge clk);
            #12;
            check("o_data_ready", 32'(o_data_ready), 32'h0);
        end
        finish_read();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/periph_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [7:0]                  i_ui_in,
    input  wire logic [bus_pkg::ADDR_W-1:0]  i_addr,
    input  wire logic [bus_pkg::DATA_W-1:0]  i_data,
    input  wire logic [1:0]                  i_data_write_n,
    input  wire logic [1:0]                  i_data_read_n,
    input  wire logic                        i_data_read_complete,
    output logic      [bus_pkg::DATA_W-1:0]  o_data,
    output logic                             o_data_ready,
    output logic      [7:0]                  o_uo_out
);

    logic [gpio_pkg::PIN_COUNT*gpio_pkg::FUNC_SEL_W-1:0] func_sel;

    periph_if user_bus ();   // GPIO slot
    periph_if byte_bus ();   // Gray coder slot

    bus_port u_bus_port (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready),
        .user_bus             (user_bus.host),
        .byte_bus             (byte_bus.host)
    );

    gpio_regs u_gpio_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ui_in    (i_ui_in),
        .o_func_sel (func_sel),
        .bus        (user_bus.dev)
    );

    gray_coder u_gray_coder (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (byte_bus.dev)
    );

    pin_router u_pin_router (
        .i_func_sel (func_sel),
        .user_bus   (user_bus.route),
        .byte_bus   (byte_bus.route),
        .o_uo_out   (o_uo_out)
    );

endmodule

`default_nettype wire

// ==== rtl/pin_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module pin_router (
    input  wire logic [gpio_pkg::PIN_COUNT*gpio_pkg::FUNC_SEL_W-1:0]  i_func_sel,
    periph_if.route                                                    user_bus,
    periph_if.route                                                    byte_bus,
    output logic      [gpio_pkg::PIN_COUNT-1:0]                        o_uo_out
);

    logic [gpio_pkg::FUNC_SEL_W-1:0] pin_sel;

    // Each pin takes its own bit from the slot its select names
    always_comb begin
        pin_sel = '0;
        for (int i = 0; i < gpio_pkg::PIN_COUNT; i++) begin
            pin_sel = i_func_sel[i*gpio_pkg::FUNC_SEL_W +: gpio_pkg::FUNC_SEL_W];
            case (pin_sel)
                gpio_pkg::FUNC_GPIO: o_uo_out[i] = user_bus.pins[i];
                gpio_pkg::FUNC_GRAY: o_uo_out[i] = byte_bus.pins[i];
                default:             o_uo_out[i] = 1'b0;    // Empty slot
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gray_coder.sv ====
`timescale 1ns/1ns
`default_nettype none

module gray_coder (
    input  wire logic  clk,
    input  wire logic  rst_n,
    periph_if.dev      bus
);

    logic [7:0]                  value;     // Stored byte
    logic [7:0]                  gray;
    logic [7:0]                  decoded;   // value taken as Gray, back to binary
    logic [bus_pkg::DATA_W-1:0]  rd_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
        end else if (bus.wr && bus.offset == 6'd0) begin
            value <= bus.wdata[7:0];
        end
    end

    assign gray = value ^ (value >> 1);

    // Prefix XOR from the top bit down
    always_comb begin
        decoded[7] = value[7];
        for (int i = 6; i >= 0; i--) begin
            decoded[i] = decoded[i+1] ^ value[i];
        end
    end

    always_comb begin
        rd_val = '0;
        case (bus.offset)
            6'd0:    rd_val[7:0] = value;
            6'd1:    rd_val[7:0] = gray;
            6'd2:    rd_val[7:0] = decoded;
            default: rd_val = '0;
        endcase
    end

    assign bus.rdata = bus.sel ? rd_val : '0;
    assign bus.pins  = gray;   // Gray code goes out on the pins

endmodule

`default_nettype wire

// ==== gpio/gpio_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpio_regs (
    input  wire logic                                            clk,
    input  wire logic                                            rst_n,
    input  wire logic [gpio_pkg::PIN_COUNT-1:0]                  i_ui_in,
    output logic [gpio_pkg::PIN_COUNT*gpio_pkg::FUNC_SEL_W-1:0]  o_func_sel,
    periph_if.dev                                                bus
);

    logic [gpio_pkg::PIN_COUNT-1:0]   gpio_out;
    logic [gpio_pkg::FUNC_SEL_W-1:0]  func_sel [gpio_pkg::PIN_COUNT];
    logic                             func_hit;
    logic [2:0]                       func_idx;
    logic [bus_pkg::DATA_W-1:0]       rd_val;

    // Function selects are word aligned from 0x20 upward
    assign func_hit = (bus.offset >= gpio_pkg::OFS_FUNC_BASE) && (bus.offset[1:0] == 2'b00);
    assign func_idx = bus.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < gpio_pkg::PIN_COUNT; i++) begin
                func_sel[i] <= gpio_pkg::FUNC_GPIO;  // Every pin starts as GPIO
            end
        end else if (bus.wr) begin
            if (bus.offset == gpio_pkg::OFS_OUT) begin
                gpio_out <= bus.wdata[gpio_pkg::PIN_COUNT-1:0];
            end
            if (func_hit) begin
                func_sel[func_idx] <= bus.wdata[gpio_pkg::FUNC_SEL_W-1:0];
            end
        end
    end

    // Register readback, zero extended
    always_comb begin
        rd_val = '0;
        if (bus.offset == gpio_pkg::OFS_OUT) begin
            rd_val[gpio_pkg::PIN_COUNT-1:0] = gpio_out;
        end else if (bus.offset == gpio_pkg::OFS_IN) begin
            rd_val[gpio_pkg::PIN_COUNT-1:0] = i_ui_in;   // Live pin state
        end else if (func_hit) begin
            rd_val[gpio_pkg::FUNC_SEL_W-1:0] = func_sel[func_idx];
        end
    end

    assign bus.rdata = bus.sel ? rd_val : '0;
    assign bus.pins  = gpio_out;

    // Flatten the selects for the pin router
    always_comb begin
        for (int i = 0; i < gpio_pkg::PIN_COUNT; i++) begin
            o_func_sel[i*gpio_pkg::FUNC_SEL_W +: gpio_pkg::FUNC_SEL_W] = func_sel[i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bus_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_port (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [bus_pkg::ADDR_W-1:0]  i_addr,
    input  wire logic [bus_pkg::DATA_W-1:0]  i_data,
    input  wire logic [1:0]                  i_data_write_n,
    input  wire logic [1:0]                  i_data_read_n,
    input  wire logic                        i_data_read_complete,
    output logic      [bus_pkg::DATA_W-1:0]  o_data,
    output logic                             o_data_ready,
    periph_if.host                           user_bus,
    periph_if.host                           byte_bus
);

    bus_pkg::periph_addr_t        addr;
    logic                         byte_region;
    logic                         write_req;
    logic                         read_req;
    logic [bus_pkg::DATA_W-1:0]   peri_data;     // Data from the addressed slot
    logic                         peri_ready;
    logic                         capture;
    logic [bus_pkg::DATA_W-1:0]   data_r;
    logic                         data_hold;
    logic                         data_ready_r;

    assign addr        = i_addr;
    assign byte_region = i_addr[bus_pkg::REGION_BIT];
    assign write_req   = i_data_write_n != bus_pkg::ACC_NONE;
    assign read_req    = i_data_read_n != bus_pkg::ACC_NONE;

    // Slot decode
    assign user_bus.sel = !byte_region && (addr.user.slot == bus_pkg::GPIO_SLOT);
    assign byte_bus.sel = byte_region && (addr.simple.slot == bus_pkg::GRAY_SLOT);

    assign user_bus.wr = write_req && user_bus.sel;
    assign byte_bus.wr = write_req && byte_bus.sel;

    assign user_bus.offset = addr.user.offset;
    assign byte_bus.offset = {2'b00, addr.simple.offset};  // Byte slots use 4 offset bits

    assign user_bus.wdata = i_data;
    assign byte_bus.wdata = i_data;

    // Read mux; empty byte slots answer at once with zero
    always_comb begin
        peri_data  = '0;
        peri_ready = 1'b0;
        if (byte_region) begin
            peri_ready = 1'b1;
            if (byte_bus.sel) peri_data = byte_bus.rdata;
        end else if (user_bus.sel) begin
            peri_ready = 1'b1;
            peri_data  = user_bus.rdata;
        end
    end

    // First ready cycle of a read loads the hold register
    assign capture = read_req && peri_ready && !data_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold    <= 1'b0;
            data_ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) data_hold <= 1'b0;
            if (capture) data_hold <= 1'b1;
            data_ready_r <= read_req && peri_ready;  // One cycle after the request
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_r <= peri_data;
    end

    assign o_data       = data_r;
    assign o_data_ready = data_ready_r || write_req;  // Writes never stall

endmodule

`default_nettype wire

// ==== common/periph_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Link between the bus port and one peripheral slot
interface periph_if;

    logic                          sel;     // Slot addressed
    logic                          wr;      // Write strobe, already qualified by sel
    logic [bus_pkg::OFFSET_W-1:0]  offset;
    logic [bus_pkg::DATA_W-1:0]    wdata;
    logic [bus_pkg::DATA_W-1:0]    rdata;   // Combinational from offset
    logic [7:0]                    pins;    // Slot output pins

    modport host (
        output sel,
        output wr,
        output offset,
        output wdata,
        input  rdata
    );

    modport dev (
        input  sel,
        input  wr,
        input  offset,
        input  wdata,
        output rdata,
        output pins
    );

    // Pin routing only looks at the outputs
    modport route (
        input  pins
    );

endinterface

`default_nettype wire

// ==== common/gpio_pkg.sv ====
`default_nettype none

// GPIO register map and pin function selects
package gpio_pkg;

    localparam int PIN_COUNT  = 8;
    localparam int FUNC_SEL_W = 5;

    // Top bit picks the byte region, low 4 bits the slot number
    localparam logic [FUNC_SEL_W-1:0] FUNC_GPIO = 5'b0_0001;  // User slot 1
    localparam logic [FUNC_SEL_W-1:0] FUNC_GRAY = 5'b1_0000;  // Byte slot 0

    // Register offsets inside the GPIO slot
    localparam logic [bus_pkg::OFFSET_W-1:0] OFS_OUT       = 6'h00;
    localparam logic [bus_pkg::OFFSET_W-1:0] OFS_IN        = 6'h04;
    localparam logic [bus_pkg::OFFSET_W-1:0] OFS_FUNC_BASE = 6'h20;  // Eight words up to 0x3C

endpackage

`default_nettype wire

// ==== common/bus_pkg.sv ====
`default_nettype none

// Peripheral bus address map and access encodings
package bus_pkg;

    localparam int ADDR_W   = 11;        // Peripheral address width
    localparam int DATA_W   = 32;        // Data word width
    localparam int OFFSET_W = 6;         // Offset inside a user slot

    localparam logic [1:0] ACC_NONE = 2'b11;  // No read or write this cycle

    // Bit 10 splits the map into user slots and byte slots
    localparam int REGION_BIT = 10;

    localparam logic [3:0] GPIO_SLOT = 4'd1;  // User slot
    localparam logic [3:0] GRAY_SLOT = 4'd0;  // Byte slot

    // One address word, decoded either as a 64-byte user slot
    // or as a 16-byte byte slot
    typedef union packed {
        struct packed {
            logic       region;
            logic [3:0] slot;                 // Address bits 9:6
            logic [5:0] offset;
        } user;
        struct packed {
            logic       region;
            logic [1:0] unused;
            logic [3:0] slot;                 // Address bits 7:4
            logic [3:0] offset;
        } simple;
    } periph_addr_t;

endpackage

`default_nettype wire
